// File: Bender.yml
package:
  name: ipod_playback

sources:
  - include_dirs:
      - common
    files:
      - common/ipod_pkg.sv
      - source/speed_reg.sv
      - source/sample_tick.sv
      - playback/playback_ctrl.sv
      - playback/flash_reader.sv
      - source/volume_meter.sv
      - source/ipod_top.sv
  - target: simulation
    include_dirs:
      - common
      - verification
    files:
      - verification/ipod_checker.sv
      - verification/ipod_tb.sv

// File: common/ipod_defs.svh
`ifndef IPOD_DEFS_SVH
`define IPOD_DEFS_SVH

// ====================
// Sample rate
// ====================

// Sample period in 50 MHz clocks, 6944 is about 7.2 kHz
`define SPEED_DEFAULT 6944
`define SPEED_STEP 64
`define SPEED_MIN 1024
`define SPEED_MAX 16384
`define PERIOD_W 16

// ====================
// Phoneme layout
// ====================

// Each phoneme is a fixed block of flash words
`define PHONEME_WORDS 16
`define PHONEME_SILENT 15
`define PHONEME_W 4
`define SAMPLES_PER_WORD 4

// ====================
// Datapath widths
// ====================

`define FLASH_ADDR_W 23
`define SAMPLE_W 8
`define LED_BAR_W 8

`endif

// File: common/ipod_pkg.sv
`default_nettype none

`include "ipod_defs.svh"

package ipod_pkg;

  // Plain vectors with a meaning
  typedef logic signed [`SAMPLE_W-1:0] sample_t;
  typedef logic [`SAMPLE_W*`SAMPLES_PER_WORD-1:0] flash_word_t;
  typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [`PERIOD_W-1:0] period_t;
  typedef logic [`PHONEME_W-1:0] phoneme_t;
  typedef logic [`LED_BAR_W-1:0] led_bar_t;

  // ====================
  // Flash bus
  // ====================

  // Master side, held while waitrequest is high
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_cmd_t;

  // Slave side
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  // Four-phase phoneme request
  typedef struct packed {
    logic     req;
    phoneme_t phoneme;
  } play_req_t;

  // Playback control FSM
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    SILENCE,
    DONE
  } play_state_t;

endpackage

`default_nettype wire

// File: playback/flash_reader.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipod_defs.svh"

module flash_reader (
  input  wire                        CLK_50M,
  input  wire                        reset,
  input  wire                        fetch_start,
  input  wire ipod_pkg::flash_addr_t fetch_base,
  input  wire                        tick,
  input  wire ipod_pkg::flash_rsp_t  flash_rsp,
  output ipod_pkg::flash_cmd_t       flash_cmd,
  output ipod_pkg::sample_t          rd_sample,
  output logic                       rd_valid,
  output logic                       rd_last
);

  import ipod_pkg::*;

  typedef logic [$clog2(`PHONEME_WORDS):0]      issue_cnt_t;
  typedef logic [$clog2(`PHONEME_WORDS)-1:0]    word_idx_t;
  typedef logic [$clog2(`SAMPLES_PER_WORD)-1:0] byte_idx_t;

  logic        cmd_read;
  flash_addr_t cmd_addr;
  issue_cnt_t  issue_cnt;
  word_idx_t   word_cnt;
  byte_idx_t   byte_idx;
  logic        waiting;
  flash_word_t cur_word;
  flash_word_t next_word;
  logic        cur_valid;
  logic        next_valid;
  logic        tick_pending;
  logic        issue;
  logic        accept;
  logic        rsp_valid;
  logic        emit;
  logic        cur_done;

  assign flash_cmd = '{read: cmd_read, address: cmd_addr};

  // One read in flight, and only when the prefetch slot is free
  assign issue = !cmd_read && !waiting && !next_valid &&
                 (issue_cnt != issue_cnt_t'(`PHONEME_WORDS));
  assign accept    = cmd_read && !flash_rsp.waitrequest;
  assign rsp_valid = waiting && flash_rsp.readdatavalid;

  // A tick, or one left over, takes the next byte
  assign emit     = (tick || tick_pending) && cur_valid;
  assign cur_done = emit && (byte_idx == byte_idx_t'(`SAMPLES_PER_WORD - 1));

  // ====================
  // Bus and buffer control
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      cmd_read     <= 1'b0;
      waiting      <= 1'b0;
      issue_cnt    <= issue_cnt_t'(`PHONEME_WORDS);
      word_cnt     <= '0;
      byte_idx     <= '0;
      cur_valid    <= 1'b0;
      next_valid   <= 1'b0;
      tick_pending <= 1'b0;
      rd_valid     <= 1'b0;
      rd_last      <= 1'b0;
    end
    else if (fetch_start)
    begin
      issue_cnt    <= '0;
      word_cnt     <= '0;
      byte_idx     <= '0;
      cur_valid    <= 1'b0;
      next_valid   <= 1'b0;
      tick_pending <= 1'b0;
      rd_valid     <= 1'b0;
      rd_last      <= 1'b0;
    end
    else
    begin
      if (issue)
        cmd_read <= 1'b1;
      else if (accept)
      begin
        cmd_read  <= 1'b0;
        waiting   <= 1'b1;
        issue_cnt <= issue_cnt + 1'b1;
      end
      if (rsp_valid)
        waiting <= 1'b0;

      rd_valid <= emit;
      rd_last  <= cur_done && (word_cnt == word_idx_t'(`PHONEME_WORDS - 1));
      if (emit)
      begin
        byte_idx     <= byte_idx + 1'b1;
        tick_pending <= tick_pending && tick;
      end
      else if (tick)
        tick_pending <= 1'b1;

      // Word slots, the prefetched word moves up when the current one ends
      if (cur_done)
      begin
        word_cnt <= word_cnt + 1'b1;
        if (next_valid)
          next_valid <= 1'b0;
        else
          cur_valid <= rsp_valid;
      end
      else if (rsp_valid)
      begin
        if (cur_valid)
          next_valid <= 1'b1;
        else
          cur_valid <= 1'b1;
      end
    end
  end

  // Address and data payload
  always_ff @(posedge CLK_50M)
  begin
    if (fetch_start)
      cmd_addr <= fetch_base;
    else if (accept)
      cmd_addr <= cmd_addr + 1'b1;
    if (emit)
      rd_sample <= cur_word[byte_idx*`SAMPLE_W +: `SAMPLE_W];
    if (cur_done && next_valid)
      cur_word <= next_word;
    else if (rsp_valid && (cur_done || !cur_valid))
      cur_word <= flash_rsp.readdata;
    if (rsp_valid && cur_valid && !cur_done)
      next_word <= flash_rsp.readdata;
  end

  a_cmd_hold: assert property (@(posedge CLK_50M) disable iff (reset)
    (cmd_read && flash_rsp.waitrequest) |=> (cmd_read && $stable(cmd_addr)));

endmodule

`default_nettype wire

// File: playback/playback_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipod_defs.svh"

module playback_ctrl (
  input  wire                       CLK_50M,
  input  wire                       reset,
  input  wire ipod_pkg::play_req_t  play,
  input  wire ipod_pkg::sample_t    rd_sample,
  input  wire                       rd_valid,
  input  wire                       rd_last,
  input  wire                       tick,
  output logic                      play_ack,
  output logic                      fetch_start,
  output ipod_pkg::flash_addr_t     fetch_base,
  output logic                      run,
  output ipod_pkg::sample_t         sample,
  output logic                      sample_valid,
  output logic                      silent
);

  import ipod_pkg::*;

  typedef logic [$clog2(`PHONEME_WORDS*`SAMPLES_PER_WORD)-1:0] sil_cnt_t;

  play_state_t state;
  sil_cnt_t    sil_cnt;

  // Sample clock only runs while a phoneme plays
  assign run = (state == FETCH) || (state == SILENCE);

  // ====================
  // Control FSM
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state        <= IDLE;
      play_ack     <= 1'b0;
      fetch_start  <= 1'b0;
      sample_valid <= 1'b0;
      silent       <= 1'b0;
      sil_cnt      <= '0;
    end
    else
    begin
      fetch_start  <= 1'b0;
      sample_valid <= 1'b0;
      case (state)
        IDLE:
          if (play.req)
          begin
            sil_cnt <= '0;
            if (play.phoneme == phoneme_t'(`PHONEME_SILENT))
            begin
              silent <= 1'b1;
              state  <= SILENCE;
            end
            else
            begin
              silent      <= 1'b0;
              fetch_start <= 1'b1;
              state       <= FETCH;
            end
          end
        FETCH:
          if (rd_valid)
          begin
            sample_valid <= 1'b1;
            if (rd_last)
              state <= DONE;
          end
        SILENCE:
          // Zeros at the sample rate, no flash traffic
          if (tick)
          begin
            sample_valid <= 1'b1;
            sil_cnt      <= sil_cnt + 1'b1;
            if (sil_cnt == '1)
              state <= DONE;
          end
        DONE:
          // Hold ack until the requester lets go
          if (play.req)
            play_ack <= 1'b1;
          else
          begin
            play_ack <= 1'b0;
            state    <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Start address and output sample
  always_ff @(posedge CLK_50M)
  begin
    if ((state == IDLE) && play.req)
      fetch_base <= flash_addr_t'(play.phoneme) << $clog2(`PHONEME_WORDS);
    if ((state == FETCH) && rd_valid)
      sample <= rd_sample;
    else if ((state == SILENCE) && tick)
      sample <= '0;
  end

  a_no_idle_sample: assert property (@(posedge CLK_50M) disable iff (reset)
    sample_valid |-> (state != IDLE));

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
+incdir+verification
common/ipod_pkg.sv
source/speed_reg.sv
source/sample_tick.sv
playback/playback_ctrl.sv
playback/flash_reader.sv
source/volume_meter.sv
source/ipod_top.sv
verification/ipod_checker.sv
verification/ipod_tb.sv

// File: source/ipod_top.sv
`default_nettype none
`timescale 1ns/100ps

module ipod_top (
  input  wire                       CLK_50M,
  input  wire                       reset,
  input  wire ipod_pkg::play_req_t  play,
  input  wire                       speed_up,
  input  wire                       speed_down,
  input  wire                       speed_restore,
  input  wire ipod_pkg::flash_rsp_t flash_rsp,
  output logic                      play_ack,
  output ipod_pkg::flash_cmd_t      flash_cmd,
  output ipod_pkg::sample_t         sample,
  output logic                      sample_valid,
  output logic                      silent,
  output ipod_pkg::period_t         speed_period,
  output ipod_pkg::led_bar_t        volume_bar
);

  import ipod_pkg::*;

  // Controller to datapath
  logic        fetch_start;
  flash_addr_t fetch_base;
  logic        run;
  logic        tick;

  // Reader back to controller
  sample_t     rd_sample;
  logic        rd_valid;
  logic        rd_last;

  playback_ctrl u_ctrl (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .play         (play),
    .rd_sample    (rd_sample),
    .rd_valid     (rd_valid),
    .rd_last      (rd_last),
    .tick         (tick),
    .play_ack     (play_ack),
    .fetch_start  (fetch_start),
    .fetch_base   (fetch_base),
    .run          (run),
    .sample       (sample),
    .sample_valid (sample_valid),
    .silent       (silent)
  );

  flash_reader u_reader (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .fetch_start (fetch_start),
    .fetch_base  (fetch_base),
    .tick        (tick),
    .flash_rsp   (flash_rsp),
    .flash_cmd   (flash_cmd),
    .rd_sample   (rd_sample),
    .rd_valid    (rd_valid),
    .rd_last     (rd_last)
  );

  // ====================
  // Sample rate
  // ====================

  speed_reg u_speed (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_restore (speed_restore),
    .period        (speed_period)
  );

  sample_tick u_tick (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .run     (run),
    .period  (speed_period),
    .tick    (tick)
  );

  volume_meter u_meter (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sample       (sample),
    .sample_valid (sample_valid),
    .volume_bar   (volume_bar)
  );

endmodule

`default_nettype wire

// File: source/sample_tick.sv
`default_nettype none
`timescale 1ns/100ps

module sample_tick (
  input  wire               CLK_50M,
  input  wire               reset,
  input  wire               run,
  input  wire ipod_pkg::period_t period,
  output logic              tick
);

  import ipod_pkg::*;

  period_t count;
  logic    run_d;

  // Counter at zero ends one period
  assign tick = run && run_d && (count == '0);

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      run_d <= 1'b0;
      count <= '0;
    end
    else
    begin
      run_d <= run;
      // Reload on the rising edge of run and after every tick
      if (run && (!run_d || tick))
        count <= period - 1'b1;
      else if (run)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/speed_reg.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipod_defs.svh"

module speed_reg (
  input  wire               CLK_50M,
  input  wire               reset,
  input  wire               speed_up,
  input  wire               speed_down,
  input  wire               speed_restore,
  output ipod_pkg::period_t period
);

  import ipod_pkg::*;

  period_t period_next;

  // Restore first, then a lone up or down step
  always_comb
  begin
    period_next = period;
    if (speed_restore)
      period_next = period_t'(`SPEED_DEFAULT);
    else if (speed_up && !speed_down)
    begin
      // Faster means a shorter period
      if (period < period_t'(`SPEED_MIN + `SPEED_STEP))
        period_next = period_t'(`SPEED_MIN);
      else
        period_next = period - period_t'(`SPEED_STEP);
    end
    else if (speed_down && !speed_up)
    begin
      if (period > period_t'(`SPEED_MAX - `SPEED_STEP))
        period_next = period_t'(`SPEED_MAX);
      else
        period_next = period + period_t'(`SPEED_STEP);
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      period <= period_t'(`SPEED_DEFAULT);
    else
      period <= period_next;
  end

  a_period_range: assert property (@(posedge CLK_50M) disable iff (reset)
    (period >= period_t'(`SPEED_MIN)) && (period <= period_t'(`SPEED_MAX)));

endmodule

`default_nettype wire

// File: source/volume_meter.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipod_defs.svh"

module volume_meter (
  input  wire                     CLK_50M,
  input  wire                     reset,
  input  wire ipod_pkg::sample_t  sample,
  input  wire                     sample_valid,
  output ipod_pkg::led_bar_t      volume_bar
);

  import ipod_pkg::*;

  logic [`SAMPLE_W-2:0] mag;
  logic [`SAMPLE_W-6:0] level;
  led_bar_t             bar_next;

  // Magnitude of a signed sample, -128 reads as 127
  always_comb
  begin
    if (!sample[`SAMPLE_W-1])
      mag = sample[`SAMPLE_W-2:0];
    else if (sample[`SAMPLE_W-2:0] == '0)
      mag = '1;
    else
      mag = ~sample[`SAMPLE_W-2:0] + 1'b1;
  end

  // Sixteen steps of magnitude per LED
  assign level = mag[`SAMPLE_W-2:4];

  always_comb
  begin
    for (int i = 0; i < `LED_BAR_W; i++)
      bar_next[i] = (i < level);
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      volume_bar <= '0;
    else if (sample_valid)
      volume_bar <= bar_next;
  end

endmodule

`default_nettype wire

// File: verification/tb_funcs.svh
// ====================
// Testbench helpers
// ====================

// 32-bit xorshift step, also the random source of the testbench
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Flash content, the word at an address is the xorshift of address XOR seed
function automatic logic [31:0] flash_word_at(input logic [31:0] addr);
  return xorshift32(addr ^ 32'h76a638bc);
endfunction

// File: verification/ipod_checker.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipod_defs.svh"

module ipod_checker (
  input wire                       CLK_50M,
  input wire                       reset,
  input wire ipod_pkg::play_req_t  play,
  input wire                       speed_up,
  input wire                       speed_down,
  input wire                       speed_restore,
  input wire ipod_pkg::flash_cmd_t flash_cmd,
  input wire ipod_pkg::flash_rsp_t flash_rsp,
  input wire                       play_ack,
  input wire ipod_pkg::sample_t    sample,
  input wire                       sample_valid,
  input wire                       silent,
  input wire ipod_pkg::period_t    speed_period,
  input wire ipod_pkg::led_bar_t   volume_bar
);

  import ipod_pkg::*;

  `include "tb_funcs.svh"

  localparam int PHONEME_SAMPLES = `PHONEME_WORDS * `SAMPLES_PER_WORD;

  int       period_errors = 0;
  int       sample_errors = 0;
  int       bar_errors = 0;
  int       handshake_errors = 0;
  int       bus_errors = 0;
  int       samples_checked = 0;

  int       exp_period;
  phoneme_t cur_phoneme;
  logic     active;
  int       sample_count;
  int       read_count;
  logic     req_d;
  logic     ack_d;
  logic     bar_due;
  led_bar_t exp_bar;

  // ====================
  // Reference model
  // ====================

  function automatic int next_period(input int cur, input logic up, input logic down,
                                     input logic restore);
    int p;
    p = cur;
    if (restore)
      p = `SPEED_DEFAULT;
    else if (up && !down)
      p = cur - `SPEED_STEP;
    else if (down && !up)
      p = cur + `SPEED_STEP;
    if (p < `SPEED_MIN)
      p = `SPEED_MIN;
    if (p > `SPEED_MAX)
      p = `SPEED_MAX;
    return p;
  endfunction

  // Sample k of a phoneme with byte 0 of each word first
  function automatic sample_t sample_at(input phoneme_t p, input int k);
    logic [31:0] word;
    if (p == phoneme_t'(`PHONEME_SILENT))
      return '0;
    word = flash_word_at(int'(p) * `PHONEME_WORDS + k / `SAMPLES_PER_WORD);
    return word[(k % `SAMPLES_PER_WORD) * `SAMPLE_W +: `SAMPLE_W];
  endfunction

  function automatic led_bar_t thermometer_bar(input sample_t s);
    int mag;
    int lit;
    mag = int'(s);
    if (mag < 0)
      mag = -mag;
    if (mag > 127)
      mag = 127;
    lit = mag / 16;
    if (lit > 8)
      lit = 8;
    return led_bar_t'((1 << lit) - 1);
  endfunction

  // Period one clock after each pulse
  always @(posedge CLK_50M)
  begin
    if (reset)
      exp_period = `SPEED_DEFAULT;
    else
    begin
      if (speed_period !== period_t'(exp_period))
      begin
        period_errors++;
        $display("** Error at %0t: speed_period is %0d, expected %0d",
                 $time, speed_period, exp_period);
      end
      exp_period = next_period(exp_period, speed_up, speed_down, speed_restore);
    end
  end

  // ====================
  // Playback checks
  // ====================

  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      active = 1'b0;
      req_d = 1'b0;
      ack_d = 1'b0;
      bar_due = 1'b0;
    end
    else
    begin
      if (bar_due && (volume_bar !== exp_bar))
      begin
        bar_errors++;
        $display("** Error at %0t: volume_bar is %b, expected %b", $time, volume_bar, exp_bar);
      end
      bar_due = sample_valid;
      exp_bar = thermometer_bar(sample);

      if (play.req && !req_d && !play_ack)
      begin
        active = 1'b1;
        cur_phoneme = play.phoneme;
        sample_count = 0;
        read_count = 0;
      end

      // Accepted flash reads
      if (flash_cmd.read && !flash_rsp.waitrequest)
      begin
        read_count++;
        if (!active || (cur_phoneme == phoneme_t'(`PHONEME_SILENT)) ||
            (int'(flash_cmd.address) < int'(cur_phoneme) * `PHONEME_WORDS) ||
            (int'(flash_cmd.address) >= (int'(cur_phoneme) + 1) * `PHONEME_WORDS))
        begin
          bus_errors++;
          $display("** Error at %0t: flash read of word %0d outside phoneme %0d",
                   $time, flash_cmd.address, cur_phoneme);
        end
      end

      if (sample_valid)
      begin
        if (!active || (sample_count >= PHONEME_SAMPLES))
        begin
          handshake_errors++;
          $display("** Error at %0t: sample_valid outside a phoneme request", $time);
        end
        else
        begin
          if ((sample !== sample_at(cur_phoneme, sample_count)) ||
              (silent !== (cur_phoneme == phoneme_t'(`PHONEME_SILENT))))
          begin
            sample_errors++;
            $display("** Error at %0t: phoneme %0d sample %0d is %0d silent %b, expected %0d",
                     $time, cur_phoneme, sample_count, sample, silent,
                     sample_at(cur_phoneme, sample_count));
          end
          sample_count++;
          samples_checked++;
        end
      end

      // Ack rises only after the full phoneme
      if (play_ack && !ack_d)
      begin
        if (!req_d || !active)
        begin
          handshake_errors++;
          $display("** Error at %0t: play_ack rose without a request", $time);
        end
        else if ((sample_count != PHONEME_SAMPLES) ||
                 (read_count != ((cur_phoneme == phoneme_t'(`PHONEME_SILENT)) ?
                                 0 : `PHONEME_WORDS)))
        begin
          handshake_errors++;
          $display("** Error at %0t: ack after %0d samples and %0d reads for phoneme %0d",
                   $time, sample_count, read_count, cur_phoneme);
        end
        active = 1'b0;
      end
      if (ack_d && !req_d && play_ack)
      begin
        handshake_errors++;
        $display("** Error at %0t: play_ack still high one clock after req fell", $time);
      end
      if (ack_d && req_d && !play_ack)
      begin
        handshake_errors++;
        $display("** Error at %0t: play_ack fell while req was high", $time);
      end
      req_d = play.req;
      ack_d = play_ack;
    end
  end

endmodule

`default_nettype wire

// File: verification/ipod_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipod_defs.svh"

module ipod_tb;

  import ipod_pkg::*;

  `include "tb_funcs.svh"

  localparam int ACK_TIMEOUT   = 70 * `SPEED_MAX;
  localparam int ACK_DROP_WAIT = 8;
  localparam int TOTAL_SAMPLES = 4 * `PHONEME_WORDS * `SAMPLES_PER_WORD;

  logic        CLK_50M;
  logic        reset;
  play_req_t   play;
  logic        speed_up;
  logic        speed_down;
  logic        speed_restore;
  flash_rsp_t  flash_rsp;
  logic        play_ack;
  flash_cmd_t  flash_cmd;
  sample_t     sample;
  logic        sample_valid;
  logic        silent;
  period_t     speed_period;
  led_bar_t    volume_bar;

  logic [31:0] rng;
  logic        slow_flash;
  logic        timed_out;

  ipod_top DUT (.*);

  ipod_checker u_checker (.*);

  always #10 CLK_50M = ~CLK_50M;

  // ====================
  // Flash memory model
  // ====================

  initial
  begin : flash_model
    int          wait_cycles;
    int          latency;
    flash_addr_t addr;
    forever
    begin
      @(posedge CLK_50M);
      #2;
      if (flash_cmd.read === 1'b1)
      begin
        addr = flash_cmd.address;
        rng = xorshift32(rng);
        wait_cycles = slow_flash ? 3 : int'(rng[1:0]);
        latency = slow_flash ? 4 : 1 + int'(rng[3:2]);
        if (wait_cycles != 0)
        begin
          flash_rsp.waitrequest = 1'b1;
          repeat (wait_cycles) @(posedge CLK_50M);
          #2;
          flash_rsp.waitrequest = 1'b0;
        end
        // Read is accepted on this edge
        @(posedge CLK_50M);
        #2;
        repeat (latency - 1)
        begin
          @(posedge CLK_50M);
          #2;
        end
        flash_rsp.readdatavalid = 1'b1;
        flash_rsp.readdata = flash_word_at(32'(addr));
        @(posedge CLK_50M);
        #2;
        flash_rsp.readdatavalid = 1'b0;
        flash_rsp.readdata = '0;
      end
    end
  end

  // One cycle of speed pulses
  task automatic pulse_speed(input logic up, input logic down, input logic restore);
    speed_up = up;
    speed_down = down;
    speed_restore = restore;
    @(posedge CLK_50M);
    #2;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_restore = 1'b0;
  endtask

  task automatic finish_run();
    int errors;
    errors = u_checker.period_errors + u_checker.sample_errors + u_checker.bar_errors +
             u_checker.handshake_errors + u_checker.bus_errors;
    $display("Errors: period %0d, sample %0d, volume %0d, handshake %0d, bus %0d; samples %0d/%0d",
             u_checker.period_errors, u_checker.sample_errors, u_checker.bar_errors,
             u_checker.handshake_errors, u_checker.bus_errors,
             u_checker.samples_checked, TOTAL_SAMPLES);
    if (u_checker.samples_checked != TOTAL_SAMPLES)
      $display("Wrong number of samples checked: %0d seen, %0d expected",
               u_checker.samples_checked, TOTAL_SAMPLES);
    if (timed_out || (errors != 0) || (u_checker.samples_checked != TOTAL_SAMPLES))
    begin
      $display("Done: errors found");
    end
    else
    begin
      $display("Done: no errors");
    end
    $finish;
  endtask

  // Full four-phase request for one phoneme
  task automatic play_phoneme(input phoneme_t p);
    int cycles;
    play.phoneme = p;
    play.req = 1'b1;
    cycles = 0;
    while (!play_ack && (cycles < ACK_TIMEOUT))
    begin
      @(posedge CLK_50M);
      #2;
      cycles++;
    end
    if (!play_ack)
    begin
      $display("Timed out after %0d cycles waiting for ack of phoneme %0d", cycles, p);
      timed_out = 1'b1;
    end
    else
    begin
      play.req = 1'b0;
      cycles = 0;
      while (play_ack && (cycles < ACK_DROP_WAIT))
      begin
        @(posedge CLK_50M);
        #2;
        cycles++;
      end
      if (play_ack)
      begin
        $display("Timed out waiting for ack of phoneme %0d to fall", p);
        timed_out = 1'b1;
      end
    end
  endtask

  initial
  begin
    CLK_50M = 1'b0;
    reset = 1'b1;
    play = '0;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_restore = 1'b0;
    flash_rsp = '0;
    rng = 32'h76a638bc;
    slow_flash = 1'b0;
    timed_out = 1'b0;
    repeat (3) @(posedge CLK_50M);
    #2;
    reset = 1'b0;

    // Single steps, cancel and restore priority
    pulse_speed(1'b1, 1'b0, 1'b0);
    pulse_speed(1'b0, 1'b1, 1'b0);
    pulse_speed(1'b1, 1'b1, 1'b0);
    pulse_speed(1'b1, 1'b0, 1'b1);
    pulse_speed(1'b0, 1'b1, 1'b1);
    // Past both limits
    repeat (100) pulse_speed(1'b1, 1'b0, 1'b0);
    repeat (250) pulse_speed(1'b0, 1'b1, 1'b0);
    for (int i = 0; i < 60; i++)
    begin
      rng = xorshift32(rng);
      pulse_speed(rng[0], rng[1], rng[2] & rng[3]);
    end
    pulse_speed(1'b0, 1'b0, 1'b1);

    play_phoneme(4'd0);
    if (!timed_out)
    begin
      // Fastest rate for the rest
      repeat (100) pulse_speed(1'b1, 1'b0, 1'b0);
      play_phoneme(4'd3);
    end
    if (!timed_out)
      play_phoneme(phoneme_t'(`PHONEME_SILENT));
    if (!timed_out)
    begin
      slow_flash = 1'b1;
      play_phoneme(4'd14);
    end
    finish_run();
  end

endmodule

`default_nettype wire
